//--- build.f
rtl/core_pkg.sv
rtl/alu.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/branch_predictor.sv
rtl/data_memory.sv
rtl/core.sv
verification/core_tb.sv

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  core_pkg::word_t    op_a,
	input  core_pkg::word_t    op_b,
	input  core_pkg::alu_op_e  alu_op,
	input  core_pkg::br_cond_e br_cond,
	output core_pkg::word_t    res,
	output logic               branch_taken
);
	import core_pkg::*;

	logic zero;		// Operands equal
	logic less;		// Signed a < b

	assign zero = (op_a == op_b);
	assign less = $signed(op_a) < $signed(op_b);

	always_comb begin
		case (alu_op)
			ALU_ADD:    res = op_a + op_b;
			ALU_SUB:    res = op_a - op_b;
			ALU_AND:    res = op_a & op_b;
			ALU_OR:     res = op_a | op_b;
			ALU_XOR:    res = op_a ^ op_b;
			ALU_SLT:    res = word_t'(less);
			ALU_PASS_B: res = op_b;
			default:    res = '0;
		endcase
	end

	// Branch outcome from the same compare
	always_comb begin
		case (br_cond)
			BR_EQ:   branch_taken = zero;
			BR_NE:   branch_taken = !zero;
			BR_LT:   branch_taken = less;
			BR_GE:   branch_taken = !less;
			default: branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
	input  logic          CLK,
	input  logic          rst,
	input  core_pkg::pc_t if_pc,
	input  logic          exe_valid_branch,
	input  core_pkg::pc_t exe_pc,
	input  core_pkg::pc_t exe_target,
	input  logic          exe_predicted,
	input  logic          exe_taken,
	output logic          if_prediction,
	output core_pkg::pc_t if_target,
	output logic          correction,
	output core_pkg::pc_t correct_pc
);
	import core_pkg::*;

	// Table, one entry per word-aligned PC slot
	logic [BHT_TAG_W-1:0] tag_q    [BHT_ENTRIES];
	pc_t                  target_q [BHT_ENTRIES];
	bht_cnt_e             cnt_q    [BHT_ENTRIES];
	logic [BHT_ENTRIES-1:0] valid_q;

	bht_idx_t             if_idx, exe_idx;
	logic [BHT_TAG_W-1:0] if_tag, exe_tag;
	logic                 if_hit, exe_hit;

	// Saturating step toward the resolved outcome
	function automatic bht_cnt_e step(bht_cnt_e cnt, logic taken);
		case (cnt)
			STRONG_NT: return taken ? WEAK_NT  : STRONG_NT;
			WEAK_NT:   return taken ? WEAK_T   : STRONG_NT;
			WEAK_T:    return taken ? STRONG_T : WEAK_NT;
			default:   return taken ? STRONG_T : WEAK_T;
		endcase
	endfunction

	////////////////////
	// Fetch lookup
	////////////////////
	assign if_idx = if_pc[2 +: BHT_IDX_W];
	assign if_tag = if_pc[PC_W-1 -: BHT_TAG_W];
	assign if_hit = valid_q[if_idx] && (tag_q[if_idx] == if_tag);

	assign if_prediction = if_hit && (cnt_q[if_idx] inside {WEAK_T, STRONG_T});
	assign if_target     = target_q[if_idx];

	////////////////////
	// Execute check
	////////////////////
	assign exe_idx = exe_pc[2 +: BHT_IDX_W];
	assign exe_tag = exe_pc[PC_W-1 -: BHT_TAG_W];
	assign exe_hit = valid_q[exe_idx] && (tag_q[exe_idx] == exe_tag);

	assign correction = exe_valid_branch && (exe_taken != exe_predicted);
	assign correct_pc = exe_taken ? exe_target : exe_pc + pc_t'(4);	// Redirect target

	// Counters and valid bits
	always_ff @(posedge CLK) begin
		if (rst) begin
			valid_q <= '0;
			for (int i = 0; i < BHT_ENTRIES; i++) begin
				cnt_q[i] <= WEAK_NT;
			end
		end else if (exe_valid_branch) begin
			valid_q[exe_idx] <= 1'b1;
			// New entry starts from the reset state
			cnt_q[exe_idx] <= exe_hit ? step(cnt_q[exe_idx], exe_taken)
			                          : step(WEAK_NT, exe_taken);
		end
	end

	// Tag and target install
	always_ff @(posedge CLK) begin
		if (exe_valid_branch) begin
			tag_q[exe_idx]    <= exe_tag;
			target_q[exe_idx] <= exe_target;
		end
	end

	// Core clears execute after a correction, so no second one can follow
	assert property (@(posedge CLK) disable iff (rst)
		correction |-> !$past(correction));

endmodule

`default_nettype wire

//--- rtl/core.sv
`timescale 1ns/1ps
`default_nettype none

module core (
	input  logic               CLK,
	input  logic               rst,
	input  core_pkg::byte_en_t con_write,
	input  core_pkg::dm_addr_t con_addr,
	input  core_pkg::word_t    con_in,
	output core_pkg::word_t    con_out
);
	import core_pkg::*;

	// Fetch
	pc_t   pc_q, pc_next, if_pc4;
	word_t rom [IM_WORDS];
	word_t if_inst;
	logic  if_prediction;
	pc_t   if_target;

	// Decode
	if_id_t if_id_q, if_id_d;
	ctrl_t  id_ctrl;
	word_t  id_imm, id_rs1_data, id_rs2_data;
	logic   id_jump;		// Valid JAL in decode
	pc_t    id_jump_target;

	// Execute
	id_exe_t id_exe_q, id_exe_d;
	word_t   exe_op_b, exe_res;
	logic    exe_taken, exe_branch;
	pc_t     exe_target;
	logic    flush;			// Mispredict, kills IF/ID and ID/EXE
	pc_t     correct_pc;

	// Memory and writeback
	exe_mem_t exe_mem_q, exe_mem_d;
	mem_wb_t  mem_wb_q, mem_wb_d;
	word_t    wb_load, wb_data;
	logic     wb_write;

	////////////////////
	// Fetch
	////////////////////
	initial $readmemh("verification/program.hex", rom);

	assign if_inst = rom[pc_q[IM_ADDR_W+1:2]];	// Async ROM read
	assign if_pc4  = pc_q + pc_t'(4);

	// Execute fix beats decode jump beats prediction
	always_comb begin
		if (flush)              pc_next = correct_pc;
		else if (id_jump)       pc_next = id_jump_target;
		else if (if_prediction) pc_next = if_target;
		else                    pc_next = if_pc4;
	end

	always_ff @(posedge CLK) begin
		if (rst) pc_q <= '0;
		else     pc_q <= pc_next;
	end

	always_comb begin
		if_id_d.valid     = !(flush || id_jump);	// Wrong-path fetch dropped
		if_id_d.pc        = pc_q;
		if_id_d.inst      = if_inst;
		if_id_d.predicted = if_prediction;
	end

	////////////////////
	// Decode
	////////////////////
	decoder u_decoder (
		.inst (if_id_q.inst),
		.ctrl (id_ctrl),
		.imm  (id_imm)
	);

	regfile u_regfile (
		.CLK       (CLK),
		.rst       (rst),
		.wr_en     (wb_write),
		.wr_addr   (mem_wb_q.rd),
		.wr_data   (wb_data),
		.rd_addr_a (if_id_q.inst[19:15]),
		.rd_addr_b (if_id_q.inst[24:20]),
		.rd_data_a (id_rs1_data),
		.rd_data_b (id_rs2_data)
	);

	assign id_jump        = if_id_q.valid && id_ctrl.is_jump;
	assign id_jump_target = if_id_q.pc + pc_t'(id_imm);

	always_comb begin
		id_exe_d.valid     = if_id_q.valid && !flush;
		id_exe_d.ctrl      = id_exe_d.valid ? id_ctrl : '0;	// Bubble carries no writes
		id_exe_d.pc        = if_id_q.pc;
		id_exe_d.rs1_data  = id_rs1_data;
		id_exe_d.rs2_data  = id_rs2_data;
		id_exe_d.imm       = id_imm;
		id_exe_d.rd        = if_id_q.inst[11:7];
		id_exe_d.predicted = if_id_q.predicted;
	end

	////////////////////
	// Execute
	////////////////////
	assign exe_op_b = id_exe_q.ctrl.sel_op_b_imm ? id_exe_q.imm : id_exe_q.rs2_data;

	alu u_alu (
		.op_a         (id_exe_q.rs1_data),
		.op_b         (exe_op_b),
		.alu_op       (id_exe_q.ctrl.alu_op),
		.br_cond      (id_exe_q.ctrl.br_cond),
		.res          (exe_res),
		.branch_taken (exe_taken)
	);

	assign exe_branch = id_exe_q.valid && (id_exe_q.ctrl.br_cond != BR_NONE);
	assign exe_target = id_exe_q.pc + pc_t'(id_exe_q.imm);

	branch_predictor u_bht (
		.CLK              (CLK),
		.rst              (rst),
		.if_pc            (pc_q),
		.exe_valid_branch (exe_branch),
		.exe_pc           (id_exe_q.pc),
		.exe_target       (exe_target),
		.exe_predicted    (id_exe_q.predicted),
		.exe_taken        (exe_taken),
		.if_prediction    (if_prediction),
		.if_target        (if_target),
		.correction       (flush),
		.correct_pc       (correct_pc)
	);

	always_comb begin
		exe_mem_d.valid      = id_exe_q.valid;
		exe_mem_d.ctrl       = id_exe_q.ctrl;
		exe_mem_d.alu_res    = exe_res;
		exe_mem_d.store_data = id_exe_q.rs2_data;
		exe_mem_d.imm        = id_exe_q.imm;
		exe_mem_d.rd         = id_exe_q.rd;
		exe_mem_d.pc4        = id_exe_q.pc + pc_t'(4);
	end

	////////////////////
	// Memory
	////////////////////
	data_memory u_dmem (
		.CLK        (CLK),
		.core_addr  (exe_mem_q.alu_res[DM_ADDR_W+1:2]),	// Word index
		.core_write (exe_mem_q.valid && exe_mem_q.ctrl.mem_write),
		.core_in    (exe_mem_q.store_data),
		.core_out   (wb_load),
		.con_write  (con_write),
		.con_addr   (con_addr),
		.con_in     (con_in),
		.con_out    (con_out)
	);

	always_comb begin
		mem_wb_d.valid   = exe_mem_q.valid;
		mem_wb_d.ctrl    = exe_mem_q.ctrl;
		mem_wb_d.alu_res = exe_mem_q.alu_res;
		mem_wb_d.imm     = exe_mem_q.imm;
		mem_wb_d.rd      = exe_mem_q.rd;
		mem_wb_d.pc4     = exe_mem_q.pc4;
	end

	// Pipeline registers, only valid and control cleared
	always_ff @(posedge CLK) begin
		if (rst) begin
			if_id_q.valid   <= 1'b0;
			id_exe_q.valid  <= 1'b0;
			id_exe_q.ctrl   <= '0;
			exe_mem_q.valid <= 1'b0;
			exe_mem_q.ctrl  <= '0;
			mem_wb_q.valid  <= 1'b0;
			mem_wb_q.ctrl   <= '0;
		end else begin
			if_id_q   <= if_id_d;
			id_exe_q  <= id_exe_d;
			exe_mem_q <= exe_mem_d;
			mem_wb_q  <= mem_wb_d;
		end
	end

	////////////////////
	// Writeback
	////////////////////
	assign wb_write = mem_wb_q.valid && mem_wb_q.ctrl.reg_write;

	always_comb begin
		case (mem_wb_q.ctrl.wb_sel)
			WB_PC4:  wb_data = word_t'(mem_wb_q.pc4);
			WB_ALU:  wb_data = mem_wb_q.alu_res;
			WB_IMM:  wb_data = mem_wb_q.imm;
			default: wb_data = wb_load;		// Registered read from data memory
		endcase
	end

	// A stale JAL in decode must lose to the fix, and both young slots die
	assert property (@(posedge CLK) disable iff (rst)
		flush |=> (pc_q == $past(correct_pc)) && !if_id_q.valid && !id_exe_q.valid);

endmodule

`default_nettype wire

//--- rtl/core_pkg.sv
`default_nettype none

package core_pkg;

	////////////////////
	// Sizes
	////////////////////
	localparam int XLEN        = 32;
	localparam int PC_W        = 12;		// Byte address of an instruction
	localparam int IM_WORDS    = 256;		// Instruction ROM depth
	localparam int IM_ADDR_W   = $clog2(IM_WORDS);
	localparam int DM_WORDS    = 1024;
	localparam int DM_ADDR_W   = $clog2(DM_WORDS);
	localparam int REG_COUNT   = 32;
	localparam int BHT_ENTRIES = 16;
	localparam int BHT_IDX_W   = $clog2(BHT_ENTRIES);
	localparam int BHT_TAG_W   = PC_W - 2 - BHT_IDX_W;	// PC bits above the index

	typedef logic [XLEN-1:0]              word_t;
	typedef logic [PC_W-1:0]              pc_t;
	typedef logic [DM_ADDR_W-1:0]         dm_addr_t;	// Word address
	typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
	typedef logic [XLEN/8-1:0]            byte_en_t;
	typedef logic [BHT_IDX_W-1:0]         bht_idx_t;

	////////////////////
	// Opcodes
	////////////////////
	localparam logic [6:0] OP_R      = 7'b0110011;
	localparam logic [6:0] OP_I      = 7'b0010011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {WB_PC4, WB_ALU, WB_IMM, WB_LOAD} wb_sel_e;

	// BR_NONE must stay zero, a cleared ctrl_t is then no branch
	typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE} br_cond_e;

	typedef enum logic [1:0] {STRONG_NT, WEAK_NT, WEAK_T, STRONG_T} bht_cnt_e;

	////////////////////
	// Pipeline contents
	////////////////////
	typedef struct packed {
		alu_op_e  alu_op;
		logic     sel_op_b_imm;		// Operand B from immediate
		logic     reg_write;
		logic     mem_write;
		wb_sel_e  wb_sel;
		br_cond_e br_cond;
		logic     is_jump;			// JAL, resolved in decode
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		pc_t   pc;
		word_t inst;
		logic  predicted;			// Fetch guessed taken
	} if_id_t;

	typedef struct packed {
		logic      valid;
		ctrl_t     ctrl;
		pc_t       pc;
		word_t     rs1_data;
		word_t     rs2_data;
		word_t     imm;
		reg_addr_t rd;
		logic      predicted;
	} id_exe_t;

	typedef struct packed {
		logic      valid;
		ctrl_t     ctrl;
		word_t     alu_res;		// Also the store address
		word_t     store_data;
		word_t     imm;
		reg_addr_t rd;
		pc_t       pc4;
	} exe_mem_t;

	typedef struct packed {
		logic      valid;
		ctrl_t     ctrl;
		word_t     alu_res;
		word_t     imm;
		reg_addr_t rd;
		pc_t       pc4;
	} mem_wb_t;

endpackage

`default_nettype wire

//--- rtl/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
	input  logic               CLK,
	input  core_pkg::dm_addr_t core_addr,
	input  logic               core_write,
	input  core_pkg::word_t    core_in,
	output core_pkg::word_t    core_out,
	input  core_pkg::byte_en_t con_write,
	input  core_pkg::dm_addr_t con_addr,
	input  core_pkg::word_t    con_in,
	output core_pkg::word_t    con_out
);
	import core_pkg::*;

	word_t mem [DM_WORDS];
	logic  con_hit;		// Controller writes the word the core targets

	assign con_hit = (con_write != '0) && (con_addr == core_addr);

	always_ff @(posedge CLK) begin
		// Pipeline port, whole word, yields to the controller
		if (core_write && !con_hit) begin
			mem[core_addr] <= core_in;
		end
		// Controller port, per byte
		for (int b = 0; b < $bits(byte_en_t); b++) begin
			if (con_write[b]) begin
				mem[con_addr][8*b +: 8] <= con_in[8*b +: 8];
			end
		end
		core_out <= mem[core_addr];		// Lands with MEM/WB
		con_out  <= mem[con_addr];
	end

	// Pipeline and controller must both present a clean address on a write
	assert property (@(posedge CLK) core_write |-> !$isunknown(core_addr));
	assert property (@(posedge CLK) (con_write != '0) |-> !$isunknown(con_addr));

endmodule

`default_nettype wire

//--- rtl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  core_pkg::word_t inst,
	output core_pkg::ctrl_t ctrl,
	output core_pkg::word_t imm
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// Immediate formats, all sign extended from bit 31
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		// NOP unless matched below
		ctrl.alu_op       = ALU_PASS_B;
		ctrl.sel_op_b_imm = 1'b0;
		ctrl.reg_write    = 1'b0;
		ctrl.mem_write    = 1'b0;
		ctrl.wb_sel       = WB_ALU;
		ctrl.br_cond      = BR_NONE;
		ctrl.is_jump      = 1'b0;
		imm               = '0;

		case (opcode)
			OP_R: begin
				ctrl.reg_write = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'h0}: ctrl.alu_op = ALU_ADD;
					{7'h20, 3'h0}: ctrl.alu_op = ALU_SUB;
					{7'h00, 3'h7}: ctrl.alu_op = ALU_AND;
					{7'h00, 3'h6}: ctrl.alu_op = ALU_OR;
					{7'h00, 3'h4}: ctrl.alu_op = ALU_XOR;
					{7'h00, 3'h2}: ctrl.alu_op = ALU_SLT;
					default:       ctrl.reg_write = 1'b0;	// Unsupported R-type
				endcase
			end
			OP_I: begin
				if (funct3 == 3'h0) begin	// ADDI only
					ctrl.alu_op       = ALU_ADD;
					ctrl.sel_op_b_imm = 1'b1;
					ctrl.reg_write    = 1'b1;
					imm               = imm_i;
				end
			end
			OP_LUI: begin
				ctrl.sel_op_b_imm = 1'b1;
				ctrl.reg_write    = 1'b1;
				ctrl.wb_sel       = WB_IMM;
				imm               = imm_u;
			end
			OP_LOAD: begin
				if (funct3 == 3'h2) begin	// LW
					ctrl.alu_op       = ALU_ADD;
					ctrl.sel_op_b_imm = 1'b1;
					ctrl.reg_write    = 1'b1;
					ctrl.wb_sel       = WB_LOAD;
					imm               = imm_i;
				end
			end
			OP_STORE: begin
				if (funct3 == 3'h2) begin	// SW
					ctrl.alu_op       = ALU_ADD;
					ctrl.sel_op_b_imm = 1'b1;
					ctrl.mem_write    = 1'b1;
					imm               = imm_s;
				end
			end
			OP_BRANCH: begin
				ctrl.alu_op = ALU_SUB;
				imm         = imm_b;
				case (funct3)
					3'h0:    ctrl.br_cond = BR_EQ;
					3'h1:    ctrl.br_cond = BR_NE;
					3'h4:    ctrl.br_cond = BR_LT;
					3'h5:    ctrl.br_cond = BR_GE;
					default: ctrl.br_cond = BR_NONE;	// Unsigned forms not decoded
				endcase
			end
			OP_JAL: begin
				ctrl.is_jump   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_PC4;	// Link address
				imm            = imm_j;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic                CLK,
	input  logic                rst,
	input  logic                wr_en,
	input  core_pkg::reg_addr_t wr_addr,
	input  core_pkg::word_t     wr_data,
	input  core_pkg::reg_addr_t rd_addr_a,
	input  core_pkg::reg_addr_t rd_addr_b,
	output core_pkg::word_t     rd_data_a,
	output core_pkg::word_t     rd_data_b
);
	import core_pkg::*;

	word_t regs_q [REG_COUNT];

	// x0 reads zero, writeback of this cycle is visible to decode
	function automatic word_t read_port(reg_addr_t addr);
		if (addr == '0) return '0;
		if (wr_en && (wr_addr == addr)) return wr_data;
		return regs_q[addr];
	endfunction

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs_q[wr_addr] <= wr_data;
		end
	end

	always_comb begin
		rd_data_a = read_port(rd_addr_a);
		rd_data_b = read_port(rd_addr_b);
	end

	// Writeback mux must never hand over an unknown
	assert property (@(posedge CLK) disable iff (rst)
		wr_en |-> !$isunknown(wr_data));

endmodule

`default_nettype wire

//--- verification/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;
	import core_pkg::*;

	localparam int    N_WORDS     = 16;
	localparam int    ROUNDS      = 4;
	localparam int    CYCLE_LIMIT = ROUNDS * (N_WORDS * 40 + 200);
	localparam word_t LFSR_SEED   = 32'd66647;
	localparam word_t LFSR_TAPS   = 32'h8020_0003;	// x^32 + x^22 + x^2 + x + 1

	// Word addresses the program uses
	localparam dm_addr_t THR_ADDR  = dm_addr_t'(16);
	localparam dm_addr_t SUM_ADDR  = dm_addr_t'(32);
	localparam dm_addr_t CNT_ADDR  = dm_addr_t'(33);
	localparam dm_addr_t XOR_ADDR  = dm_addr_t'(34);
	localparam dm_addr_t DONE_ADDR = dm_addr_t'(40);

	typedef word_t [N_WORDS-1:0] data_set_t;

	typedef struct packed {
		word_t sum;
		word_t count;		// Words signed-less than threshold
		word_t xor_all;
	} result_t;

	logic     CLK;
	logic     rst;
	byte_en_t con_write;
	dm_addr_t con_addr;
	word_t    con_in;
	word_t    con_out;

	word_t     lfsr_q;
	data_set_t data_q;		// Inputs of the current round
	word_t     thr_q;
	bit        run_go;		// Program released from reset
	bit        run_checked;
	int        cycle_count = 0;

	core dut (
		.CLK       (CLK),
		.rst       (rst),
		.con_write (con_write),
		.con_addr  (con_addr),
		.con_in    (con_in),
		.con_out   (con_out)
	);

	always #5 CLK = ~CLK;

	////////////////////
	// Helpers
	////////////////////
	function automatic word_t lfsr_next(word_t s);
		if (s[0]) return (s >> 1) ^ LFSR_TAPS;
		return s >> 1;
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int n, output word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// What the program should leave in words 32 to 34
	function automatic result_t expected_result(data_set_t words, word_t threshold);
		result_t r;
		r = '0;
		for (int i = 0; i < N_WORDS; i++) begin
			r.sum     = r.sum + words[i];		// Wraps at 32 bits
			r.xor_all = r.xor_all ^ words[i];
			if ($signed(words[i]) < $signed(threshold)) r.count = r.count + 1;
		end
		return r;
	endfunction

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Single-cycle controller strobe
	task automatic write_word(input dm_addr_t addr, input byte_en_t be, input word_t data);
		@(negedge CLK);
		con_addr  = addr;
		con_write = be;
		con_in    = data;
		@(negedge CLK);
		con_write = '0;
	endtask

	task automatic read_word(input dm_addr_t addr, output word_t data);
		@(negedge CLK);
		con_addr = addr;
		@(negedge CLK);
		data = con_out;		// Registered read, one cycle later
	endtask

	task automatic make_round_data();
		word_t raw;
		word_t delta;
		take_bits(32, raw);
		thr_q = $signed(raw) >>> 2;		// Leaves room on both sides
		for (int i = 0; i < N_WORDS; i++) begin
			take_bits(32, raw);
			data_q[i] = raw;
		end
		take_bits(8, delta);
		delta = delta + 1;
		// Equal, above and below the threshold for sure
		data_q[2]  = thr_q;
		data_q[7]  = thr_q + delta;
		data_q[12] = thr_q - delta;
	endtask

	task automatic compare_inputs(input string tag);
		word_t rd_val;
		for (int i = 0; i < N_WORDS; i++) begin
			read_word(dm_addr_t'(i), rd_val);
			check_word($sformatf("%s word %0d", tag, i), data_q[i], rd_val);
		end
		read_word(THR_ADDR, rd_val);
		check_word($sformatf("%s threshold", tag), thr_q, rd_val);
	endtask

	task automatic compare_outputs(input string tag, input result_t exp_res);
		word_t rd_val;
		read_word(SUM_ADDR, rd_val);
		check_word($sformatf("%s sum", tag), exp_res.sum, rd_val);
		read_word(CNT_ADDR, rd_val);
		check_word($sformatf("%s count", tag), exp_res.count, rd_val);
		read_word(XOR_ADDR, rd_val);
		check_word($sformatf("%s xor", tag), exp_res.xor_all, rd_val);
		read_word(DONE_ADDR, rd_val);
		check_word($sformatf("%s done", tag), 32'd1, rd_val);
	endtask

	// Loaded while the core sits in reset
	task automatic load_memory(input int round);
		word_t rd_val;
		for (int i = 0; i < N_WORDS; i++) begin
			write_word(dm_addr_t'(i), '1, data_q[i]);
		end
		write_word(THR_ADDR, '1, {thr_q[31:16], ~thr_q[15:0]});
		// Low half merges under old upper half
		write_word(THR_ADDR, 4'b0011, {~thr_q[31:16], thr_q[15:0]});
		write_word(DONE_ADDR, '1, '0);
		compare_inputs($sformatf("round %0d readback", round));
		read_word(DONE_ADDR, rd_val);
		check_word($sformatf("round %0d readback done", round), '0, rd_val);
	endtask

	////////////////////
	// Stimulus
	////////////////////
	initial begin : drive_rounds
		CLK       = 1'b0;
		rst       = 1'b1;
		con_write = '0;
		con_addr  = '0;
		con_in    = '0;
		lfsr_q    = LFSR_SEED;
		for (int r = 0; r < ROUNDS; r++) begin
			@(negedge CLK);
			rst = 1'b1;
			repeat (5) @(negedge CLK);
			make_round_data();
			load_memory(r);
			@(negedge CLK);
			rst    = 1'b0;
			run_go = 1'b1;
			wait (run_checked);
			run_go = 1'b0;
			wait (!run_checked);
		end
		$display("TEST PASS");
		$finish;
	end

	////////////////////
	// Result check
	////////////////////
	initial begin : compare_results
		result_t exp_res;
		word_t   rd_val;
		int      round;
		round = 0;
		forever begin
			wait (run_go);
			exp_res = expected_result(data_q, thr_q);
			rd_val  = '0;
			while (rd_val !== 32'd1) begin		// Bounded by the cycle limit
				read_word(DONE_ADDR, rd_val);
			end
			compare_outputs($sformatf("round %0d result", round), exp_res);
			// Spin on JAL must leave memory alone
			repeat (50) @(negedge CLK);
			compare_inputs($sformatf("round %0d after spin", round));
			compare_outputs($sformatf("round %0d after spin", round), exp_res);
			round++;
			run_checked = 1'b1;
			wait (!run_go);
			run_checked = 1'b0;
		end
	end

	// Run limit over all rounds
	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Program did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$fatal(1, "cycle limit reached");
		end
	end

endmodule

`default_nettype wire

//--- verification/program.hex
// One instruction word per line from byte address 0, assembly after the word
04002183  // 00: lw   x3, 64(x0)     threshold
04000113  // 04: addi x2, x0, 64     end pointer
00000093  // 08: addi x1, x0, 0      pointer
00000213  // 0c: addi x4, x0, 0      sum
00000293  // 10: addi x5, x0, 0      count
00000313  // 14: addi x6, x0, 0      xor
0100006f  // 18: jal  x0, loop
00128293  // 1c: inc:  addi x5, x5, 1
00209463  // 20: bne  x1, x2, loop
0200006f  // 24: jal  x0, done
0000a383  // 28: loop: lw x7, 0(x1)
00408093  // 2c: addi x1, x1, 4
00000013  // 30: nop
00720233  // 34: add  x4, x4, x7
00734333  // 38: xor  x6, x6, x7
fe33c0e3  // 3c: blt  x7, x3, inc
fe2094e3  // 40: bne  x1, x2, loop
08402023  // 44: done: sw x4, 128(x0)
08502223  // 48: sw   x5, 132(x0)
08602423  // 4c: sw   x6, 136(x0)
00100413  // 50: addi x8, x0, 1
00000013  // 54: nop
00000013  // 58: nop
0a802023  // 5c: sw   x8, 160(x0)    done flag
0000006f  // 60: spin: jal x0, spin
